/* common/isa_pkg.sv */
package isa_pkg;

  // major opcode, bits 30..25 of every instruction word
  typedef enum logic [5:0] {
    OP_ALU_R = 6'b100000,
    OP_MOVI  = 6'b100010,
    OP_ADDI  = 6'b101000,
    OP_XORI  = 6'b101011,
    OP_ORI   = 6'b101100
  } opcode_t;

  // sub-opcode of the register form, bits 4..0
  typedef enum logic [4:0] {
    SUB_ADD   = 5'b00000,
    SUB_SUB   = 5'b00001,
    SUB_AND   = 5'b00010,
    SUB_XOR   = 5'b00011,
    SUB_OR    = 5'b00100,
    SUB_SLLI  = 5'b01000,
    SUB_SRLI  = 5'b01001,
    SUB_ROTRI = 5'b01011
  } sub_op_t;

  // how the operand stage widens the immediate field
  typedef enum logic [1:0] {
    IMM_ZE5  = 2'b00,
    IMM_SE15 = 2'b01,
    IMM_ZE15 = 2'b10,
    IMM_SE20 = 2'b11
  } imm_mode_t;

  // register form: two sources, shift amount and sub-op
  typedef struct packed {
    logic       rsv;
    opcode_t    opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] imm5;
    sub_op_t    sub;
  } r_form_t;

  // immediate form: one source and a 15-bit immediate
  typedef struct packed {
    logic        rsv;
    opcode_t     opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm15;
  } i_form_t;

  // move form, only the destination and a 20-bit immediate
  typedef struct packed {
    logic        rsv;
    opcode_t     opcode;
    logic [4:0]  rt;
    logic [19:0] imm20;
  } m_form_t;

  // one word, three ways to read it
  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
    m_form_t m_form;
  } instr_u;

endpackage

/* common/core_pkg.sv */
package core_pkg;

  // datapath width
  localparam int DATA_W = 32;

  // register file geometry
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // controller phases, one instruction at a time
  //   idle  -> waiting for a strobe
  //   fetch -> register read
  //   exec  -> alu
  //   wb    -> register write
  typedef enum logic [1:0] {
    PH_IDLE  = 2'b00,
    PH_FETCH = 2'b01,
    PH_EXEC  = 2'b10,
    PH_WB    = 2'b11
  } phase_t;

endpackage

/* hdl/controller.sv */
`timescale 1ns/1ns

module controller
  import isa_pkg::*, core_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              instr_valid,
  input  instr_u            instruction,
  output logic              enable_fetch,
  output logic              enable_execute,
  output logic              enable_writeback,
  output opcode_t           opcode,
  output sub_op_t           sub_opcode,
  output logic [REG_AW-1:0] read_address1,
  output logic [REG_AW-1:0] read_address2,
  output logic [REG_AW-1:0] write_address,
  output logic [4:0]        imm_5bit,
  output logic [14:0]       imm_15bit,
  output logic [19:0]       imm_20bit,
  output imm_mode_t         imm_mode,
  output logic              imm_reg_select,
  output logic              writeback_select
);

  phase_t phase;
  instr_u ir;
  logic   known_op;
  logic   is_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE:  if (instr_valid) phase <= PH_FETCH;
        PH_FETCH: phase <= PH_EXEC;
        PH_EXEC:  phase <= PH_WB;
        default:  phase <= PH_IDLE;
      endcase
    end
  end

  // instruction word held until the next accepted strobe
  always_ff @(posedge clk) begin
    if (phase == PH_IDLE && instr_valid) begin
      ir <= instruction;
    end
  end

  // field extraction, the views share the opcode and rt positions
  assign opcode        = ir.r_form.opcode;
  assign sub_opcode    = ir.r_form.sub;
  assign write_address = ir.r_form.rt;
  assign read_address1 = ir.r_form.ra;
  assign read_address2 = ir.r_form.rb;
  assign imm_5bit      = ir.r_form.imm5;
  assign imm_15bit     = ir.i_form.imm15;
  assign imm_20bit     = ir.m_form.imm20;

  assign is_shift = (opcode == OP_ALU_R) &&
                    (sub_opcode == SUB_SRLI || sub_opcode == SUB_SLLI ||
                     sub_opcode == SUB_ROTRI);

  always_comb begin
    known_op       = 1'b1;
    imm_mode       = IMM_ZE5;
    imm_reg_select = 1'b1;
    case (opcode)
      OP_ALU_R: imm_reg_select = is_shift;
      OP_ADDI:  imm_mode = IMM_SE15;
      OP_ORI:   imm_mode = IMM_ZE15;
      OP_XORI:  imm_mode = IMM_ZE15;
      OP_MOVI:  imm_mode = IMM_SE20;
      default:  known_op = 1'b0;
    endcase
  end

  // movi bypasses the alu and writes the extended immediate
  assign writeback_select = (opcode != OP_MOVI);

  assign enable_fetch     = (phase == PH_FETCH);
  assign enable_execute   = (phase == PH_EXEC);
  assign enable_writeback = (phase == PH_WB) && known_op;

  a_enables_exclusive: assert property (@(posedge clk) disable iff (reset)
    $onehot0({enable_fetch, enable_execute, enable_writeback}))
    else $error("controller: more than one phase enable high");

  // the source must wait for the previous instruction to finish
  a_strobe_in_idle: assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> phase == PH_IDLE)
    else $error("controller: instr_valid while an instruction is in flight");

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ns

module regfile
  import core_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              read,
  input  logic              write,
  input  logic [REG_AW-1:0] read_address1,
  input  logic [REG_AW-1:0] read_address2,
  input  logic [REG_AW-1:0] write_address,
  input  logic [DATA_W-1:0] write_data,
  output logic [DATA_W-1:0] read_data1,
  output logic [DATA_W-1:0] read_data2
);

  logic [DATA_W-1:0] regs [NUM_REGS];

  // every register starts at zero, r0 included
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_address] <= write_data;
    end
  end

  // two registered read ports, captured in the fetch phase
  always_ff @(posedge clk) begin
    if (read) begin
      read_data1 <= regs[read_address1];
      read_data2 <= regs[read_address2];
    end
  end

  a_write_addr_known: assert property (@(posedge clk) disable iff (reset)
    write |-> !$isunknown(write_address))
    else $error("regfile: write with unknown address");

endmodule

/* alu/alu32.sv */
`timescale 1ns/1ns

module alu32
  import isa_pkg::*, core_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_execute,
  input  opcode_t           opcode,
  input  sub_op_t           sub_opcode,
  input  logic [DATA_W-1:0] scr1,
  input  logic [DATA_W-1:0] scr2,
  output logic [DATA_W-1:0] alu_result,
  output logic              alu_overflow
);

  logic [DATA_W-1:0]   sum;
  logic [DATA_W-1:0]   diff;
  logic [2*DATA_W-1:0] rot;
  logic [4:0]          shamt;
  logic                add_ovf;
  logic                sub_ovf;
  logic [DATA_W-1:0]   next_result;
  logic                next_ovf;
  logic                logic_or_shift;

  assign shamt = scr2[4:0];
  assign sum   = scr1 + scr2;
  assign diff  = scr1 - scr2;
  assign rot   = {scr1, scr1} >> shamt;

  // signed overflow: operands agree in sign, result does not
  assign add_ovf = (scr1[DATA_W-1] == scr2[DATA_W-1]) &&
                   (sum[DATA_W-1] != scr1[DATA_W-1]);
  assign sub_ovf = (scr1[DATA_W-1] != scr2[DATA_W-1]) &&
                   (diff[DATA_W-1] != scr1[DATA_W-1]);

  always_comb begin
    next_result    = '0;
    next_ovf       = 1'b0;
    logic_or_shift = 1'b1;
    case (opcode)
      OP_ALU_R: begin
        case (sub_opcode)
          SUB_ADD: begin
            next_result    = sum;
            next_ovf       = add_ovf;
            logic_or_shift = 1'b0;
          end
          SUB_SUB: begin
            next_result    = diff;
            next_ovf       = sub_ovf;
            logic_or_shift = 1'b0;
          end
          SUB_AND:   next_result = scr1 & scr2;
          SUB_OR:    next_result = scr1 | scr2;
          SUB_XOR:   next_result = scr1 ^ scr2;
          SUB_SRLI:  next_result = scr1 >> shamt;
          SUB_SLLI:  next_result = scr1 << shamt;
          SUB_ROTRI: next_result = rot[DATA_W-1:0];
          default:   logic_or_shift = 1'b0;
        endcase
      end
      OP_ADDI: begin
        next_result    = sum;
        next_ovf       = add_ovf;
        logic_or_shift = 1'b0;
      end
      OP_ORI:  next_result = scr1 | scr2;
      OP_XORI: next_result = scr1 ^ scr2;
      // movi result is written from the operand stage, pass it anyway
      OP_MOVI: begin
        next_result    = scr2;
        logic_or_shift = 1'b0;
      end
      default: logic_or_shift = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_result   <= '0;
      alu_overflow <= 1'b0;
    end else if (enable_execute) begin
      alu_result   <= next_result;
      alu_overflow <= next_ovf;
    end
  end

  a_no_ovf_logic_shift: assert property (@(posedge clk) disable iff (reset)
    enable_execute && logic_or_shift |=> !alu_overflow)
    else $error("alu32: overflow flagged after a logic or shift operation");

endmodule

/* hdl/operand_select.sv */
`timescale 1ns/1ns

module operand_select
  import isa_pkg::*, core_pkg::*;
(
  input  logic [4:0]        imm_5bit,
  input  logic [14:0]       imm_15bit,
  input  logic [19:0]       imm_20bit,
  input  imm_mode_t         imm_mode,
  input  logic              imm_reg_select,
  input  logic              writeback_select,
  input  logic [DATA_W-1:0] read_data2,
  input  logic [DATA_W-1:0] alu_result,
  output logic [DATA_W-1:0] scr2,
  output logic [DATA_W-1:0] write_data
);

  logic [DATA_W-1:0] imm_ext;

  // widen the selected immediate field
  always_comb begin
    case (imm_mode)
      IMM_ZE5: begin
        imm_ext = {{(DATA_W-5){1'b0}}, imm_5bit};
      end
      IMM_SE15: begin
        imm_ext = {{(DATA_W-15){imm_15bit[14]}}, imm_15bit};
      end
      IMM_ZE15: begin
        imm_ext = {{(DATA_W-15){1'b0}}, imm_15bit};
      end
      default: begin
        imm_ext = {{(DATA_W-20){imm_20bit[19]}}, imm_20bit};
      end
    endcase
  end

  // second alu operand, immediate or register
  assign scr2 = imm_reg_select ? imm_ext : read_data2;

  // writeback data, alu result or operand directly (movi)
  assign write_data = writeback_select ? alu_result : scr2;

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ns

module core_top
  import isa_pkg::*, core_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              instr_valid,
  input  instr_u            instruction,
  output logic              wb_valid,
  output logic              alu_overflow,
  output logic [REG_AW-1:0] wb_addr,
  output logic [DATA_W-1:0] wb_data
);

  logic              enable_fetch;
  logic              enable_execute;
  logic              enable_writeback;
  opcode_t           opcode;
  sub_op_t           sub_opcode;
  logic [REG_AW-1:0] read_address1;
  logic [REG_AW-1:0] read_address2;
  logic [REG_AW-1:0] write_address;
  logic [4:0]        imm_5bit;
  logic [14:0]       imm_15bit;
  logic [19:0]       imm_20bit;
  imm_mode_t         imm_mode;
  logic              imm_reg_select;
  logic              writeback_select;
  logic [DATA_W-1:0] read_data1;
  logic [DATA_W-1:0] read_data2;
  logic [DATA_W-1:0] scr2;
  logic [DATA_W-1:0] write_data;
  logic [DATA_W-1:0] alu_result;

  controller u_controller (
    .clk              (clk),
    .reset            (reset),
    .instr_valid      (instr_valid),
    .instruction      (instruction),
    .enable_fetch     (enable_fetch),
    .enable_execute   (enable_execute),
    .enable_writeback (enable_writeback),
    .opcode           (opcode),
    .sub_opcode       (sub_opcode),
    .read_address1    (read_address1),
    .read_address2    (read_address2),
    .write_address    (write_address),
    .imm_5bit         (imm_5bit),
    .imm_15bit        (imm_15bit),
    .imm_20bit        (imm_20bit),
    .imm_mode         (imm_mode),
    .imm_reg_select   (imm_reg_select),
    .writeback_select (writeback_select)
  );

  regfile u_regfile (
    .clk           (clk),
    .reset         (reset),
    .read          (enable_fetch),
    .write         (enable_writeback),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .write_data    (write_data),
    .read_data1    (read_data1),
    .read_data2    (read_data2)
  );

  alu32 u_alu (
    .clk            (clk),
    .reset          (reset),
    .enable_execute (enable_execute),
    .opcode         (opcode),
    .sub_opcode     (sub_opcode),
    .scr1           (read_data1),
    .scr2           (scr2),
    .alu_result     (alu_result),
    .alu_overflow   (alu_overflow)
  );

  operand_select u_operand_select (
    .imm_5bit         (imm_5bit),
    .imm_15bit        (imm_15bit),
    .imm_20bit        (imm_20bit),
    .imm_mode         (imm_mode),
    .imm_reg_select   (imm_reg_select),
    .writeback_select (writeback_select),
    .read_data2       (read_data2),
    .alu_result       (alu_result),
    .scr2             (scr2),
    .write_data       (write_data)
  );

  // writeback is visible outside for checking
  assign wb_valid = enable_writeback;
  assign wb_addr  = write_address;
  assign wb_data  = write_data;

endmodule

/* test/tb_core.sv */
`timescale 1ns/1ns

module tb_core
  import isa_pkg::*, core_pkg::*;
();

  // instruction counts per test group, used for the timeout limit
  localparam int N_FIRST    = 2;
  localparam int N_LOAD     = NUM_REGS;
  localparam int N_EXT_DIR  = 4;
  localparam int N_EXT      = 40;
  localparam int N_ROP      = 60;
  localparam int N_SHIFT    = 30;
  localparam int N_BOUND    = 13;
  localparam int N_UNKNOWN  = 4;
  localparam int N_READBACK = NUM_REGS;
  localparam int N_INSTR    = N_FIRST + N_LOAD + N_EXT_DIR + N_EXT + N_ROP + N_SHIFT +
                              N_BOUND + N_UNKNOWN + N_READBACK;
  localparam int CYCLE_LIMIT = 4 * N_INSTR + 100;

  logic              clk;
  logic              reset;
  logic              instr_valid;
  instr_u            instruction;
  logic              wb_valid;
  logic              alu_overflow;
  logic [REG_AW-1:0] wb_addr;
  logic [DATA_W-1:0] wb_data;

  // reference model state
  logic [DATA_W-1:0] shadow [NUM_REGS];
  logic              exp_wb;
  logic [REG_AW-1:0] exp_addr;
  logic [DATA_W-1:0] exp_data;
  logic              exp_ovf;
  logic [2:0]        strobe_hist;
  logic              wb_expected;
  integer            seed;
  int                cycles;

  sub_op_t    r_ops [5]   = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR};
  sub_op_t    sh_ops [3]  = '{SUB_SRLI, SUB_SLLI, SUB_ROTRI};
  logic [5:0] bad_ops [4] = '{6'h00, 6'h3f, 6'h21, 6'h2a};

  core_top UUT (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instruction  (instruction),
    .wb_valid     (wb_valid),
    .alu_overflow (alu_overflow),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  // writeback is due exactly 3 cycles after an accepted strobe
  always @(posedge clk) begin
    strobe_hist <= {strobe_hist[1:0], instr_valid};
  end

  assign wb_expected = strobe_hist[2] && exp_wb;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("timeout after %0d cycles, stimulus never finished", cycles));
    end
  end

  a_wb_valid: assert property (@(posedge clk) disable iff (reset) wb_valid == wb_expected)
    else stop_on_error($sformatf("FAIL wb_valid expected %h got %h",
                                 $sampled(wb_expected), $sampled(wb_valid)));

  a_wb_addr: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_addr == exp_addr)
    else stop_on_error($sformatf("FAIL wb_addr expected %h got %h",
                                 $sampled(exp_addr), $sampled(wb_addr)));

  a_wb_data: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_data == exp_data)
    else stop_on_error($sformatf("FAIL wb_data expected %h got %h",
                                 $sampled(exp_data), $sampled(wb_data)));

  a_overflow: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> alu_overflow == exp_ovf)
    else stop_on_error($sformatf("FAIL alu_overflow expected %h got %h",
                                 $sampled(exp_ovf), $sampled(alu_overflow)));

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rand5();
    logic [31:0] r;
    r = rand32();
    return r[4:0];
  endfunction

  // one strobe, then hold off until the next issue slot 4 cycles later
  task automatic issue(input logic [31:0] word, input logic wb, input logic [4:0] rt,
                       input logic [31:0] data, input logic ovf);
    @(negedge clk);
    instruction = word;
    instr_valid = 1'b1;
    exp_wb      = wb;
    exp_addr    = rt;
    exp_data    = data;
    exp_ovf     = ovf;
    if (wb) begin
      shadow[rt] = data;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic run_r(input sub_op_t sub, input logic [4:0] rt, input logic [4:0] ra,
                       input logic [4:0] rb, input logic [4:0] imm5);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [32:0] wide;
    logic        ovf;
    a    = shadow[ra];
    b    = shadow[rb];
    ovf  = 1'b0;
    res  = '0;
    // 33-bit sign-extended sum, overflow when the top two bits differ
    wide = (sub == SUB_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
    case (sub)
      SUB_ADD, SUB_SUB: begin
        res = wide[31:0];
        ovf = wide[32] ^ wide[31];
      end
      SUB_AND:   res = a & b;
      SUB_OR:    res = a | b;
      SUB_XOR:   res = a ^ b;
      SUB_SRLI:  res = a >> imm5;
      SUB_SLLI:  res = a << imm5;
      default:   res = (a >> imm5) | (a << (32 - imm5));
    endcase
    issue({1'b0, OP_ALU_R, rt, ra, rb, imm5, sub}, 1'b1, rt, res, ovf);
  endtask

  task automatic run_i(input opcode_t op, input logic [4:0] rt, input logic [4:0] ra,
                       input logic [14:0] imm15);
    logic [31:0] a;
    logic [31:0] res;
    logic [32:0] wide;
    logic        ovf;
    a   = shadow[ra];
    ovf = 1'b0;
    case (op)
      OP_ADDI: begin
        wide = {a[31], a} + {{18{imm15[14]}}, imm15};
        res  = wide[31:0];
        ovf  = wide[32] ^ wide[31];
      end
      OP_ORI:  res = a | {17'b0, imm15};
      default: res = a ^ {17'b0, imm15};
    endcase
    issue({1'b0, op, rt, ra, imm15}, 1'b1, rt, res, ovf);
  endtask

  task automatic run_movi(input logic [4:0] rt, input logic [19:0] imm20);
    issue({1'b0, OP_MOVI, rt, imm20}, 1'b1, rt, {{12{imm20[19]}}, imm20}, 1'b0);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [4:0]  amount;
    seed        = 32'h148940f1;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instruction = '0;
    exp_wb      = 1'b0;
    exp_addr    = '0;
    exp_data    = '0;
    exp_ovf     = 1'b0;
    strobe_hist = '0;
    cycles      = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // r20 still holds zero from reset
    run_movi(5'd1, 20'(rand32() >> 12));
    run_r(SUB_ADD, 5'd2, 5'd1, 5'd20, 5'd0);
    for (int i = 0; i < N_LOAD; i++) begin
      run_movi(5'(i), 20'(rand32() >> 12));
    end

    // extension with the top immediate bit set
    run_movi(5'd3, 20'h80000);
    run_i(OP_ADDI, 5'd4, 5'd3, 15'h4000);
    run_i(OP_ORI, 5'd5, 5'd4, 15'h7fff);
    run_i(OP_XORI, 5'd6, 5'd5, 15'h4001);
    for (int i = 0; i < N_EXT; i++) begin
      rnd = rand32();
      case (rnd[1:0])
        2'd0:    run_movi(rand5(), 20'(rand32() >> 12));
        2'd1:    run_i(OP_ADDI, rand5(), rand5(), rnd[30:16]);
        2'd2:    run_i(OP_ORI, rand5(), rand5(), rnd[30:16]);
        default: run_i(OP_XORI, rand5(), rand5(), rnd[30:16]);
      endcase
    end

    for (int i = 0; i < N_ROP; i++) begin
      rnd = rand32();
      run_r(r_ops[rnd[15:0] % 5], rand5(), rand5(), rand5(), rand5());
    end

    for (int i = 0; i < N_SHIFT; i++) begin
      rnd    = rand32();
      amount = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : rnd[20:16];
      run_r(sh_ops[rnd[7:0] % 3], rand5(), rand5(), rand5(), amount);
    end

    // r1 = 32'h7fffffff, r2 = 32'h80000000
    run_movi(5'd1, 20'h7ffff);
    run_r(SUB_SLLI, 5'd1, 5'd1, 5'd0, 5'd12);
    run_i(OP_ORI, 5'd1, 5'd1, 15'h7fff);
    run_movi(5'd2, 20'h80000);
    run_r(SUB_SLLI, 5'd2, 5'd2, 5'd0, 5'd12);
    run_r(SUB_ADD, 5'd3, 5'd1, 5'd1, 5'd0);
    run_r(SUB_ADD, 5'd4, 5'd1, 5'd2, 5'd0);
    run_r(SUB_SUB, 5'd5, 5'd2, 5'd1, 5'd0);
    run_r(SUB_SUB, 5'd6, 5'd1, 5'd2, 5'd0);
    run_i(OP_ADDI, 5'd7, 5'd1, 15'h0001);
    run_i(OP_ADDI, 5'd8, 5'd2, 15'h7fff);
    run_r(SUB_ADD, 5'd9, 5'd2, 5'd2, 5'd0);
    run_r(SUB_SUB, 5'd10, 5'd2, 5'd2, 5'd0);

    // no writeback expected, the shadow copy stays as it is
    for (int i = 0; i < N_UNKNOWN; i++) begin
      issue({1'b0, bad_ops[i], rand5(), 20'(rand32() >> 12)}, 1'b0, '0, '0, 1'b0);
    end
    for (int i = 0; i < N_READBACK; i++) begin
      run_r(SUB_OR, 5'(i), 5'(i), 5'(i), 5'd0);
    end

    repeat (4) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

/* list.f */
common/isa_pkg.sv
common/core_pkg.sv
hdl/controller.sv
hdl/regfile.sv
alu/alu32.sv
hdl/operand_select.sv
hdl/core_top.sv
test/tb_core.sv

/* Makefile */
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
